//--- axi_req_arbiter.sv
module axi_req_arbiter (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  aw_valid_i,
    output logic                                  aw_ready_o,
    input  logic [axi_reqrsp_pkg::ADDR_W-1:0]     aw_addr_i,
    input  logic [axi_reqrsp_pkg::SIZE_W-1:0]     aw_size_i,
    input  logic [axi_reqrsp_pkg::LEN_W-1:0]      aw_len_i,
    input  logic [axi_reqrsp_pkg::ID_W-1:0]       aw_id_i,
    input  logic                                  ar_valid_i,
    output logic                                  ar_ready_o,
    input  logic [axi_reqrsp_pkg::ADDR_W-1:0]     ar_addr_i,
    input  logic [axi_reqrsp_pkg::SIZE_W-1:0]     ar_size_i,
    input  logic [axi_reqrsp_pkg::LEN_W-1:0]      ar_len_i,
    input  logic [axi_reqrsp_pkg::ID_W-1:0]       ar_id_i,
    input  logic                                  queue_full_i,
    output logic                                  push_o,
    output logic [axi_reqrsp_pkg::REQ_META_W-1:0] entry_o
);

    // Round-robin flag, high when AR wins the next tie
    logic prefer_ar_q;
    logic sel_ar;
    axi_reqrsp_pkg::req_kind_e sel_kind;
    logic [axi_reqrsp_pkg::ADDR_W-1:0] sel_addr;
    logic [axi_reqrsp_pkg::ADDR_W-1:0] align_mask;
    logic [axi_reqrsp_pkg::SIZE_W-1:0] sel_size;
    logic [axi_reqrsp_pkg::LEN_W-1:0] sel_len;
    logic [axi_reqrsp_pkg::ID_W-1:0] sel_id;

    // The flag only matters when both channels compete
    assign sel_ar = (aw_valid_i && ar_valid_i) ? prefer_ar_q : ar_valid_i;

    assign sel_kind = sel_ar ? axi_reqrsp_pkg::REQ_READ : axi_reqrsp_pkg::REQ_WRITE;
    assign sel_addr = sel_ar ? ar_addr_i : aw_addr_i;
    assign sel_size = sel_ar ? ar_size_i : aw_size_i;
    assign sel_len = sel_ar ? ar_len_i : aw_len_i;
    assign sel_id = sel_ar ? ar_id_i : aw_id_i;

    // Clear the low address bits below the transfer size
    assign align_mask = {axi_reqrsp_pkg::ADDR_W{1'b1}} << sel_size;

    assign push_o = (aw_valid_i || ar_valid_i) && !queue_full_i;
    assign aw_ready_o = push_o && !sel_ar;
    assign ar_ready_o = push_o && sel_ar;

    assign entry_o = {sel_kind, sel_addr & align_mask, sel_size, sel_len, sel_id};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prefer_ar_q <= 1'b0;
        end else if (push_o) begin
            // Hand the next tie to the channel that was not served
            prefer_ar_q <= !sel_ar;
        end
    end

    // A channel that loses the tie keeps its request up until it is served
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_i && !aw_ready_o |=> aw_valid_i)
        else $error("axi_req_arbiter: aw_valid_i dropped before aw_ready_o");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_o |=> ar_valid_i)
        else $error("axi_req_arbiter: ar_valid_i dropped before ar_ready_o");

endmodule

//--- axi_reqrsp_pkg.sv
package axi_reqrsp_pkg;

    // Bus widths, both sides carry the same data width
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ALIGN_W = $clog2(STRB_W);

    // AXI request attributes
    localparam int ID_W = 4;
    localparam int LEN_W = 8;
    localparam int SIZE_W = 3;

    // Metadata queues between the three stages
    localparam int QUEUE_DEPTH = 4;
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // Request entry is {kind, addr, size, len, id}
    localparam int REQ_META_W = 1 + ADDR_W + SIZE_W + LEN_W + ID_W;

    // Response entry is {kind, last, id}
    localparam int RSP_META_W = 1 + 1 + ID_W;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

endpackage

//--- axi_rsp_builder.sv
module axi_rsp_builder (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [axi_reqrsp_pkg::RSP_META_W-1:0] rsp_entry_i,
    input  logic                                  rsp_empty_i,
    output logic                                  rsp_pop_o,
    input  logic                                  pvalid_i,
    output logic                                  pready_o,
    input  logic [axi_reqrsp_pkg::DATA_W-1:0]     pdata_i,
    input  logic                                  perror_i,
    output logic                                  r_valid_o,
    input  logic                                  r_ready_i,
    output logic [axi_reqrsp_pkg::DATA_W-1:0]     r_data_o,
    output logic [1:0]                            r_resp_o,
    output logic                                  r_last_o,
    output logic [axi_reqrsp_pkg::ID_W-1:0]       r_id_o,
    output logic                                  b_valid_o,
    input  logic                                  b_ready_i,
    output logic [1:0]                            b_resp_o,
    output logic [axi_reqrsp_pkg::ID_W-1:0]       b_id_o
);

    axi_reqrsp_pkg::req_kind_e head_kind;
    logic head_last;
    logic [axi_reqrsp_pkg::ID_W-1:0] head_id;
    logic is_write;
    logic err_q;
    logic burst_err;

    assign head_kind = axi_reqrsp_pkg::req_kind_e'(rsp_entry_i[axi_reqrsp_pkg::RSP_META_W-1]);
    assign {head_last, head_id} = rsp_entry_i[axi_reqrsp_pkg::RSP_META_W-2:0];
    assign is_write = (head_kind == axi_reqrsp_pkg::REQ_WRITE);

    // Error seen so far in the write burst, including the current beat
    assign burst_err = err_q || perror_i;

    // Reads pass straight through, writes only surface on their last beat
    assign r_valid_o = !rsp_empty_i && !is_write && pvalid_i;
    assign b_valid_o = !rsp_empty_i && is_write && head_last && pvalid_i;

    assign r_data_o = pdata_i;
    assign r_resp_o = perror_i ? axi_reqrsp_pkg::RESP_DECERR : axi_reqrsp_pkg::RESP_OKAY;
    assign r_last_o = head_last;
    assign r_id_o = head_id;

    assign b_resp_o = burst_err ? axi_reqrsp_pkg::RESP_DECERR : axi_reqrsp_pkg::RESP_OKAY;
    assign b_id_o = head_id;

    // Intermediate write beats are absorbed without waiting on the AXI side
    always_comb begin
        pready_o = 1'b0;
        if (!rsp_empty_i) begin
            if (!is_write) begin
                pready_o = r_ready_i;
            end else if (head_last) begin
                pready_o = b_ready_i;
            end else begin
                pready_o = 1'b1;
            end
        end
    end

    assign rsp_pop_o = pvalid_i && pready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_q <= 1'b0;
        end else if (rsp_pop_o && is_write) begin
            // The B transfer closes the burst and starts the next one clean
            err_q <= head_last ? 1'b0 : burst_err;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) pvalid_i |-> !rsp_empty_i)
        else $error("axi_rsp_builder: response arrived with no queued entry");

endmodule

//--- axi_to_reqrsp.f
axi_reqrsp_pkg.sv
meta_fifo.sv
axi_req_arbiter.sv
reqrsp_issuer.sv
axi_rsp_builder.sv
axi_to_reqrsp.sv
tb_axi_to_reqrsp.sv

//--- axi_to_reqrsp.sv
module axi_to_reqrsp (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // AXI write address
    input  logic                              aw_valid_i,
    output logic                              aw_ready_o,
    input  logic [axi_reqrsp_pkg::ADDR_W-1:0] aw_addr_i,
    input  logic [axi_reqrsp_pkg::SIZE_W-1:0] aw_size_i,
    input  logic [axi_reqrsp_pkg::LEN_W-1:0]  aw_len_i,
    input  logic [axi_reqrsp_pkg::ID_W-1:0]   aw_id_i,
    // AXI read address
    input  logic                              ar_valid_i,
    output logic                              ar_ready_o,
    input  logic [axi_reqrsp_pkg::ADDR_W-1:0] ar_addr_i,
    input  logic [axi_reqrsp_pkg::SIZE_W-1:0] ar_size_i,
    input  logic [axi_reqrsp_pkg::LEN_W-1:0]  ar_len_i,
    input  logic [axi_reqrsp_pkg::ID_W-1:0]   ar_id_i,
    // AXI write data
    input  logic                              w_valid_i,
    output logic                              w_ready_o,
    input  logic [axi_reqrsp_pkg::DATA_W-1:0] w_data_i,
    input  logic [axi_reqrsp_pkg::STRB_W-1:0] w_strb_i,
    input  logic                              w_last_i,
    // AXI read data
    output logic                              r_valid_o,
    input  logic                              r_ready_i,
    output logic [axi_reqrsp_pkg::DATA_W-1:0] r_data_o,
    output logic [1:0]                        r_resp_o,
    output logic                              r_last_o,
    output logic [axi_reqrsp_pkg::ID_W-1:0]   r_id_o,
    // AXI write response
    output logic                              b_valid_o,
    input  logic                              b_ready_i,
    output logic [1:0]                        b_resp_o,
    output logic [axi_reqrsp_pkg::ID_W-1:0]   b_id_o,
    // REQRSP request
    output logic                              qvalid_o,
    input  logic                              qready_i,
    output logic [axi_reqrsp_pkg::ADDR_W-1:0] qaddr_o,
    output logic                              qwrite_o,
    output logic [axi_reqrsp_pkg::DATA_W-1:0] qdata_o,
    output logic [axi_reqrsp_pkg::STRB_W-1:0] qstrb_o,
    // REQRSP response
    input  logic                              pvalid_i,
    output logic                              pready_o,
    input  logic [axi_reqrsp_pkg::DATA_W-1:0] pdata_i,
    input  logic                              perror_i
);

    logic req_push;
    logic req_pop;
    logic req_full;
    logic req_empty;
    logic [axi_reqrsp_pkg::REQ_META_W-1:0] req_in;
    logic [axi_reqrsp_pkg::REQ_META_W-1:0] req_out;

    logic rsp_push;
    logic rsp_pop;
    logic rsp_full;
    logic rsp_empty;
    logic [axi_reqrsp_pkg::RSP_META_W-1:0] rsp_in;
    logic [axi_reqrsp_pkg::RSP_META_W-1:0] rsp_out;

    axi_req_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .aw_valid_i   (aw_valid_i),
        .aw_ready_o   (aw_ready_o),
        .aw_addr_i    (aw_addr_i),
        .aw_size_i    (aw_size_i),
        .aw_len_i     (aw_len_i),
        .aw_id_i      (aw_id_i),
        .ar_valid_i   (ar_valid_i),
        .ar_ready_o   (ar_ready_o),
        .ar_addr_i    (ar_addr_i),
        .ar_size_i    (ar_size_i),
        .ar_len_i     (ar_len_i),
        .ar_id_i      (ar_id_i),
        .queue_full_i (req_full),
        .push_o       (req_push),
        .entry_o      (req_in)
    );

    meta_fifo #(
        .WIDTH (axi_reqrsp_pkg::REQ_META_W)
    ) u_req_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (req_push),
        .data_i  (req_in),
        .pop_i   (req_pop),
        .data_o  (req_out),
        .full_o  (req_full),
        .empty_o (req_empty)
    );

    reqrsp_issuer u_issuer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_entry_i (req_out),
        .req_empty_i (req_empty),
        .req_pop_o   (req_pop),
        .w_valid_i   (w_valid_i),
        .w_ready_o   (w_ready_o),
        .w_data_i    (w_data_i),
        .w_strb_i    (w_strb_i),
        .w_last_i    (w_last_i),
        .rsp_full_i  (rsp_full),
        .rsp_push_o  (rsp_push),
        .rsp_entry_o (rsp_in),
        .qvalid_o    (qvalid_o),
        .qready_i    (qready_i),
        .qaddr_o     (qaddr_o),
        .qwrite_o    (qwrite_o),
        .qdata_o     (qdata_o),
        .qstrb_o     (qstrb_o)
    );

    meta_fifo #(
        .WIDTH (axi_reqrsp_pkg::RSP_META_W)
    ) u_rsp_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (rsp_push),
        .data_i  (rsp_in),
        .pop_i   (rsp_pop),
        .data_o  (rsp_out),
        .full_o  (rsp_full),
        .empty_o (rsp_empty)
    );

    axi_rsp_builder u_builder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rsp_entry_i (rsp_out),
        .rsp_empty_i (rsp_empty),
        .rsp_pop_o   (rsp_pop),
        .pvalid_i    (pvalid_i),
        .pready_o    (pready_o),
        .pdata_i     (pdata_i),
        .perror_i    (perror_i),
        .r_valid_o   (r_valid_o),
        .r_ready_i   (r_ready_i),
        .r_data_o    (r_data_o),
        .r_resp_o    (r_resp_o),
        .r_last_o    (r_last_o),
        .r_id_o      (r_id_o),
        .b_valid_o   (b_valid_o),
        .b_ready_i   (b_ready_i),
        .b_resp_o    (b_resp_o),
        .b_id_o      (b_id_o)
    );

endmodule

//--- meta_fifo.sv
module meta_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    logic [WIDTH-1:0] mem [axi_reqrsp_pkg::QUEUE_DEPTH];
    logic [axi_reqrsp_pkg::PTR_W-1:0] wr_ptr_q;
    logic [axi_reqrsp_pkg::PTR_W-1:0] rd_ptr_q;
    logic [axi_reqrsp_pkg::PTR_W:0] count_q;

    assign full_o = (count_q == axi_reqrsp_pkg::QUEUE_DEPTH);
    assign empty_o = (count_q == 0);
    assign data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == axi_reqrsp_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == axi_reqrsp_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            // A simultaneous push and pop leaves the fill level unchanged
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
        else $error("meta_fifo: push while full");

    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
        else $error("meta_fifo: pop while empty");

endmodule

//--- reqrsp_issuer.sv
module reqrsp_issuer (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [axi_reqrsp_pkg::REQ_META_W-1:0] req_entry_i,
    input  logic                                  req_empty_i,
    output logic                                  req_pop_o,
    input  logic                                  w_valid_i,
    output logic                                  w_ready_o,
    input  logic [axi_reqrsp_pkg::DATA_W-1:0]     w_data_i,
    input  logic [axi_reqrsp_pkg::STRB_W-1:0]     w_strb_i,
    input  logic                                  w_last_i,
    input  logic                                  rsp_full_i,
    output logic                                  rsp_push_o,
    output logic [axi_reqrsp_pkg::RSP_META_W-1:0] rsp_entry_o,
    output logic                                  qvalid_o,
    input  logic                                  qready_i,
    output logic [axi_reqrsp_pkg::ADDR_W-1:0]     qaddr_o,
    output logic                                  qwrite_o,
    output logic [axi_reqrsp_pkg::DATA_W-1:0]     qdata_o,
    output logic [axi_reqrsp_pkg::STRB_W-1:0]     qstrb_o
);

    axi_reqrsp_pkg::req_kind_e head_kind;
    logic [axi_reqrsp_pkg::ADDR_W-1:0] head_addr;
    logic [axi_reqrsp_pkg::SIZE_W-1:0] head_size;
    logic [axi_reqrsp_pkg::LEN_W-1:0] head_len;
    logic [axi_reqrsp_pkg::ID_W-1:0] head_id;

    logic [axi_reqrsp_pkg::LEN_W-1:0] beat_q;
    logic [axi_reqrsp_pkg::ADDR_W-1:0] addr_q;
    logic [axi_reqrsp_pkg::ADDR_W-1:0] cur_addr;
    logic [axi_reqrsp_pkg::ADDR_W-1:0] addr_step;
    logic [axi_reqrsp_pkg::STRB_W-1:0] size_mask;
    logic [axi_reqrsp_pkg::STRB_W-1:0] byte_mask;
    logic is_write;
    logic is_last;
    logic handshake;

    assign head_kind = axi_reqrsp_pkg::req_kind_e'(req_entry_i[axi_reqrsp_pkg::REQ_META_W-1]);
    assign {head_addr, head_size, head_len, head_id} =
        req_entry_i[axi_reqrsp_pkg::REQ_META_W-2:0];

    assign is_write = (head_kind == axi_reqrsp_pkg::REQ_WRITE);

    // The first beat of a burst takes its address straight from the queue head
    assign cur_addr = (beat_q == '0) ? head_addr : addr_q;
    assign is_last = (beat_q == head_len);
    assign addr_step = {{(axi_reqrsp_pkg::ADDR_W-1){1'b0}}, 1'b1} << head_size;

    // Lower 2^size bytes set, then moved to the byte offset of the beat
    assign size_mask = ~({axi_reqrsp_pkg::STRB_W{1'b1}} << (1 << head_size));
    assign byte_mask = size_mask << cur_addr[axi_reqrsp_pkg::ALIGN_W-1:0];

    // A write beat waits for its W data, a read needs only the queues
    assign qvalid_o = !req_empty_i && !rsp_full_i && (!is_write || w_valid_i);
    assign handshake = qvalid_o && qready_i;

    assign qaddr_o = cur_addr;
    assign qwrite_o = is_write;
    assign qdata_o = w_data_i;
    assign qstrb_o = is_write ? (w_strb_i & byte_mask) : byte_mask;

    assign w_ready_o = handshake && is_write;
    assign req_pop_o = handshake && is_last;

    // Every REQRSP request gets exactly one response entry
    assign rsp_push_o = handshake;
    assign rsp_entry_o = {head_kind, is_last, head_id};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
            addr_q <= '0;
        end else if (handshake) begin
            if (is_last) begin
                beat_q <= '0;
            end else begin
                beat_q <= beat_q + 1'b1;
                addr_q <= cur_addr + addr_step;
            end
        end
    end

    // Request and its payload hold steady while the memory side stalls
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        qvalid_o && !qready_i |=> qvalid_o && $stable(qaddr_o) && $stable(qstrb_o))
        else $error("reqrsp_issuer: request dropped before qready_i");

    // The burst length from AW has to agree with the master's W last flag
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_i && w_ready_o |-> (w_last_i == is_last))
        else $error("reqrsp_issuer: w_last_i does not match AWLEN");

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_axi_to_reqrsp -f axi_to_reqrsp.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "test passed" && exit 0 || exit 1

//--- tb_axi_to_reqrsp.sv
module tb_axi_to_reqrsp;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BURSTS = 10;
    localparam int WATCHDOG_CYCLES = NUM_BURSTS * 256 * 10;

    logic clk_i;
    logic rst_ni;
    logic aw_valid_i, aw_ready_o, ar_valid_i, ar_ready_o;
    logic [31:0] aw_addr_i, ar_addr_i;
    logic [2:0] aw_size_i, ar_size_i;
    logic [7:0] aw_len_i, ar_len_i;
    logic [3:0] aw_id_i, ar_id_i;
    logic w_valid_i, w_ready_o, w_last_i;
    logic [31:0] w_data_i;
    logic [3:0] w_strb_i;
    logic r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i;
    logic [31:0] r_data_o;
    logic [1:0] r_resp_o, b_resp_o;
    logic [3:0] r_id_o, b_id_o;
    logic qvalid_o, qready_i, qwrite_o, pvalid_i, pready_o, perror_i;
    logic [31:0] qaddr_o, qdata_o, pdata_i;
    logic [3:0] qstrb_o;

    // Burst table, filled by the test sequence and read by the checker
    logic bst_write [NUM_BURSTS];
    logic [31:0] bst_addr [NUM_BURSTS];
    logic [2:0] bst_size [NUM_BURSTS];
    logic [7:0] bst_len [NUM_BURSTS];
    logic [3:0] bst_id [NUM_BURSTS];
    logic [31:0] bst_data [NUM_BURSTS][256];
    logic [3:0] bst_strb [NUM_BURSTS][256];

    logic [7:0] mem [logic [31:0]];
    logic [7:0] shadow [logic [31:0]];
    int order_q [$];
    // Expected response entry is {is_b, last, resp, id, data}
    logic [39:0] exp_q [$];
    int aw_cur, ar_cur, done_cnt, expect_done, checks, errors;
    int beat_idx = 0;
    logic acc_err = 1'b0;
    logic stall_en;
    integer seed = 61532;

    axi_to_reqrsp dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: bursts still incomplete after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // Unwritten bytes read back a pattern built from all address bits
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k+:8] = shadow.exists(a + k) ? shadow[a + k] : fill_byte(a + k);
        end
        return w;
    endfunction

    // Expected {address, active byte mask} of one beat of an INCR burst
    function automatic logic [35:0] beat_ref(input int n, input int beat);
        logic [31:0] addr;
        logic [3:0] mask;
        int nbytes;
        nbytes = 1 << bst_size[n];
        addr = (bst_addr[n] & ~(nbytes - 1)) + beat * nbytes;
        mask = 4'(((1 << nbytes) - 1) << addr[1:0]);
        return {addr, mask};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic set_burst(input int n, input logic wr, input logic [31:0] addr,
                             input logic [2:0] size, input logic [7:0] len,
                             input logic [3:0] id, input logic rand_strb);
        logic [31:0] r;
        bst_write[n] = wr;
        bst_addr[n] = addr;
        bst_size[n] = size;
        bst_len[n] = len;
        bst_id[n] = id;
        for (int i = 0; i <= len; i++) begin
            bst_data[n][i] = $random(seed);
            r = $random(seed);
            bst_strb[n][i] = rand_strb ? r[3:0] : 4'hf;
        end
    endtask

    task automatic send_aw(input int n);
        aw_cur = n;
        aw_addr_i = bst_addr[n];
        aw_size_i = bst_size[n];
        aw_len_i = bst_len[n];
        aw_id_i = bst_id[n];
        aw_valid_i = 1'b1;
        @(negedge clk_i);
        while (!aw_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        aw_valid_i = 1'b0;
    endtask

    task automatic send_ar(input int n);
        ar_cur = n;
        ar_addr_i = bst_addr[n];
        ar_size_i = bst_size[n];
        ar_len_i = bst_len[n];
        ar_id_i = bst_id[n];
        ar_valid_i = 1'b1;
        @(negedge clk_i);
        while (!ar_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        ar_valid_i = 1'b0;
    endtask

    task automatic send_w(input int n);
        for (int i = 0; i <= bst_len[n]; i++) begin
            w_data_i = bst_data[n][i];
            w_strb_i = bst_strb[n][i];
            w_last_i = (i == bst_len[n]);
            w_valid_i = 1'b1;
            @(negedge clk_i);
            while (!w_ready_o) @(negedge clk_i);
            @(posedge clk_i);
            #1;
        end
        w_valid_i = 1'b0;
        w_last_i = 1'b0;
    endtask

    task automatic run_write(input int n);
        fork
            send_aw(n);
            send_w(n);
        join
    endtask

    task automatic wait_done(input int bursts);
        expect_done += bursts;
        @(posedge clk_i);
        while (done_cnt < expect_done) @(posedge clk_i);
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        $display("Test %0d, %s: %0d mismatches", num, name, errors - err0);
    endtask

    // Memory side answers one request at a time with 0 to 3 cycles of latency
    initial begin : memory_model
        logic [31:0] wa;
        logic [31:0] r;
        int lat;
        @(posedge rst_ni);
        qready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (qvalid_o && qready_i) begin
                wa = {qaddr_o[31:2], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    if (qwrite_o && qstrb_o[k]) mem[wa + k] = qdata_o[8*k+:8];
                    pdata_i[8*k+:8] = mem.exists(wa + k) ? mem[wa + k] : fill_byte(wa + k);
                end
                perror_i = (qaddr_o[31:28] == 4'hf);
                r = $random(seed);
                lat = r[1:0];
                @(posedge clk_i);
                #1;
                qready_i = 1'b0;
                if (lat > 0) begin
                    repeat (lat) @(posedge clk_i);
                    #1;
                end
                pvalid_i = 1'b1;
                @(negedge clk_i);
                while (!pready_o) @(negedge clk_i);
                @(posedge clk_i);
                #1;
                pvalid_i = 1'b0;
                qready_i = 1'b1;
            end
        end
    end

    always begin : ready_stall
        logic [31:0] r;
        @(posedge clk_i);
        #1;
        r = $random(seed);
        r_ready_i = stall_en ? r[0] : 1'b1;
        b_ready_i = stall_en ? r[1] : 1'b1;
    end

    // Handshakes are sampled half a cycle before the edge that completes them
    always @(negedge clk_i) begin : monitor
        logic [35:0] ref_beat;
        logic [39:0] e;
        logic [31:0] wa;
        logic [3:0] strb;
        logic err;
        int n;
        if (rst_ni) begin
            if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected response beat at %0t ns, nothing outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("response is B", b_valid_o, e[39]);
                    check_value("response id", r_valid_o ? r_id_o : b_id_o, e[35:32]);
                    check_value("response code", r_valid_o ? r_resp_o : b_resp_o, e[37:36]);
                    if (r_valid_o) begin
                        check_value("r_data", r_data_o, e[31:0]);
                        check_value("r_last", r_last_o, e[38]);
                    end
                    if (e[38]) done_cnt++;
                end
            end
            if (aw_valid_i && aw_ready_o) order_q.push_back(aw_cur);
            if (ar_valid_i && ar_ready_o) order_q.push_back(ar_cur);
            if (qvalid_o && qready_i) begin
                if (order_q.size() == 0) begin
                    errors++;
                    $display("REQRSP request at %0t ns with no accepted burst", $time);
                end else begin
                    n = order_q[0];
                    ref_beat = beat_ref(n, beat_idx);
                    wa = {ref_beat[35:6], 2'b00};
                    err = (ref_beat[35:32] == 4'hf);
                    strb = bst_write[n] ? (bst_strb[n][beat_idx] & ref_beat[3:0]) : ref_beat[3:0];
                    check_value("qaddr", qaddr_o, ref_beat[35:4]);
                    check_value("qwrite", qwrite_o, bst_write[n]);
                    check_value("qstrb", qstrb_o, strb);
                    if (bst_write[n]) begin
                        check_value("qdata", qdata_o, bst_data[n][beat_idx]);
                        for (int k = 0; k < 4; k++) begin
                            if (strb[k]) shadow[wa + k] = bst_data[n][beat_idx][8*k+:8];
                        end
                        acc_err = acc_err | err;
                    end else begin
                        exp_q.push_back({1'b0, beat_idx == bst_len[n], err ? 2'b11 : 2'b00,
                                         bst_id[n], shadow_word(wa)});
                    end
                    if (beat_idx == bst_len[n]) begin
                        if (bst_write[n]) begin
                            exp_q.push_back({2'b11, acc_err ? 2'b11 : 2'b00, bst_id[n], 32'h0});
                        end
                        void'(order_q.pop_front());
                        beat_idx = 0;
                        acc_err = 1'b0;
                    end else begin
                        beat_idx++;
                    end
                end
            end
        end
    end

    initial begin
        int err0;
        {aw_valid_i, ar_valid_i, w_valid_i, w_last_i, qready_i, pvalid_i, perror_i} = '0;
        {aw_addr_i, aw_size_i, aw_len_i, aw_id_i} = '0;
        {ar_addr_i, ar_size_i, ar_len_i, ar_id_i} = '0;
        {w_data_i, w_strb_i, pdata_i} = '0;
        r_ready_i = 1'b1;
        b_ready_i = 1'b1;
        stall_en = 1'b0;
        rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        err0 = errors;
        set_burst(0, 1'b1, 32'h100, 3'd2, 8'd7, 4'd1, 1'b0);
        set_burst(1, 1'b0, 32'h100, 3'd2, 8'd7, 4'd2, 1'b0);
        run_write(0);
        wait_done(1);
        send_ar(1);
        wait_done(1);
        report_test(1, "full-word write then read", err0);

        // Byte bursts from an odd address step one byte per beat
        err0 = errors;
        set_burst(2, 1'b1, 32'h203, 3'd0, 8'd5, 4'd3, 1'b0);
        set_burst(3, 1'b0, 32'h203, 3'd0, 8'd5, 4'd4, 1'b0);
        run_write(2);
        wait_done(1);
        send_ar(3);
        wait_done(1);
        report_test(2, "narrow unaligned burst", err0);

        // The read address is not halfword aligned
        err0 = errors;
        set_burst(4, 1'b1, 32'h300, 3'd2, 8'd3, 4'd5, 1'b0);
        set_burst(5, 1'b0, 32'h103, 3'd1, 8'd9, 4'd6, 1'b0);
        fork
            run_write(4);
            send_ar(5);
        join
        wait_done(2);
        report_test(3, "concurrent AW and AR", err0);

        // Only the first write beats hit the error region while the read runs into it
        err0 = errors;
        set_burst(6, 1'b1, 32'hffff_fff8, 3'd2, 8'd3, 4'd7, 1'b0);
        set_burst(7, 1'b0, 32'hefff_fff8, 3'd2, 8'd3, 4'd8, 1'b0);
        run_write(6);
        wait_done(1);
        send_ar(7);
        wait_done(1);
        report_test(4, "error region", err0);

        err0 = errors;
        stall_en = 1'b1;
        set_burst(8, 1'b1, 32'h400, 3'd2, 8'd15, 4'd9, 1'b1);
        set_burst(9, 1'b0, 32'h400, 3'd1, 8'd31, 4'd10, 1'b0);
        fork
            run_write(8);
            send_ar(9);
        join
        wait_done(2);
        stall_en = 1'b0;
        report_test(5, "random stalls and latency", err0);

        repeat (4) @(posedge clk_i);
        if (exp_q.size() != 0 || order_q.size() != 0) begin
            errors++;
            $display("Responses or bursts were still outstanding at the end of the run");
        end
        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
